//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_dac_fifo
FILELIST  := project.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
rtl/dac_fifo_pkg.sv
rtl/dac_fifo_regs.sv
rtl/avl_dacfifo_fetch.sv
rtl/dac_fifo_buffer.sv
rtl/dac_fifo_drain.sv
rtl/dac_fifo_top.sv
verification/tb_avl_memory.sv
verification/tb_dac_fifo.sv

//--- rtl/avl_dacfifo_fetch.sv
// Fetches the waveform from memory with single Avalon reads, one at a time.
// The word address wraps to 0 after last_address. Clearing the enable resets
// the address and the write pointer at once; a read still in flight at that
// point is dropped when it returns.

module avl_dacfifo_fetch (
  input  logic                                            dac_clk,
  input  logic                                            dac_reset,
  input  logic                                            xfer_enable,
  input  logic [dac_fifo_pkg::avl_address_width-1:0]      last_address,
  input  logic [dac_fifo_pkg::avl_byteenable_width-1:0]   last_byteenable,
  input  logic                                            avl_ready,
  input  logic                                            avl_readdatavalid,
  input  logic [dac_fifo_pkg::avl_data_width-1:0]         avl_data,
  input  logic [dac_fifo_pkg::dac_mem_address_width-1:0]  rd_address,
  output logic [dac_fifo_pkg::avl_address_width-1:0]      avl_address,
  output logic                                            avl_read,
  output logic [dac_fifo_pkg::avl_byteenable_width-1:0]   avl_byteenable,
  output logic                                            wr_enable,
  output logic [dac_fifo_pkg::avl_mem_address_width-1:0]  wr_address,
  output logic [dac_fifo_pkg::avl_data_width-1:0]         wr_data,
  output logic                                            last_word_written
);

  logic [dac_fifo_pkg::avl_mem_address_width-1:0] level_s;
  logic request_s;
  logic request_data;
  logic waiting;
  logic stale;
  logic keep_s;
  logic last_s;

  // ======================================================================
  // Fill level and read hysteresis
  // ======================================================================

  assign level_s = wr_address -
    rd_address[dac_fifo_pkg::dac_mem_address_width-1 -: dac_fifo_pkg::avl_mem_address_width];

  always_comb begin
    if (level_s <= dac_fifo_pkg::mem_threshold_lo) begin
      request_s = 1'b1;
    end else if (level_s >= dac_fifo_pkg::mem_threshold_hi) begin
      request_s = 1'b0;
    end else begin
      request_s = request_data;
    end
  end

  // avl_read stays up until the memory takes it
  always_ff @(posedge dac_clk) begin
    if (dac_reset || !xfer_enable) begin
      request_data <= 1'b0;
      avl_read <= 1'b0;
    end else begin
      request_data <= request_s;
      if (avl_read && avl_ready) begin
        avl_read <= 1'b0;
      end else if (!avl_read && !waiting && request_s) begin
        avl_read <= 1'b1;
      end
    end
  end

  // Track the outstanding read across a disable so its data can be dropped
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      waiting <= 1'b0;
      stale <= 1'b0;
    end else begin
      if (avl_read && avl_ready) begin
        waiting <= 1'b1;
      end else if (avl_readdatavalid) begin
        waiting <= 1'b0;
      end
      if (avl_readdatavalid) begin
        stale <= 1'b0;
      end else if (!xfer_enable && (waiting || (avl_read && avl_ready))) begin
        stale <= 1'b1;
      end
    end
  end

  // ======================================================================
  // Address generation and buffer write
  // ======================================================================

  assign keep_s = avl_readdatavalid & ~stale & xfer_enable;
  assign last_s = (avl_address >= last_address);
  assign avl_byteenable = last_s ? last_byteenable : '1;

  always_ff @(posedge dac_clk) begin
    if (dac_reset || !xfer_enable) begin
      avl_address <= '0;
      wr_address <= '0;
      wr_enable <= 1'b0;
      last_word_written <= 1'b0;
    end else begin
      wr_enable <= keep_s;
      last_word_written <= keep_s & last_s;
      if (keep_s) begin
        avl_address <= last_s ? '0 : avl_address + 1'b1;
      end
      if (wr_enable) begin
        wr_address <= wr_address + 1'b1;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (avl_readdatavalid) begin
      wr_data <= avl_data;
    end
  end

  assert property (@(posedge dac_clk) disable iff (dac_reset)
    avl_readdatavalid |-> waiting)
    else $error("Avalon read data returned with no read outstanding");

endmodule

//--- rtl/dac_fifo_buffer.sv
// Asymmetric buffer, written one wide word and read one narrow lane.
// The width ratio must be a power of two; rd_data follows rd_address after
// one cycle. Writing and reading one word in the same cycle returns old data.

module dac_fifo_buffer #(
  parameter int a_address_width = 4,
  parameter int b_address_width = 6,
  parameter int a_data_width = 128,
  parameter int b_data_width = 32
) (
  input  logic                        dac_clk,
  input  logic                        wr_enable,
  input  logic [a_address_width-1:0]  wr_address,
  input  logic [a_data_width-1:0]     wr_data,
  input  logic [b_address_width-1:0]  rd_address,
  output logic [b_data_width-1:0]     rd_data
);

  logic [a_data_width-1:0] mem [2**a_address_width];
  logic [a_address_width-1:0] rd_word_s;
  logic [b_address_width-1:0] rd_lane_s;

  // High bits select the word, low bits the lane within it
  assign rd_word_s = a_address_width'(rd_address >> (b_address_width - a_address_width));
  assign rd_lane_s = rd_address & b_address_width'(a_data_width / b_data_width - 1);

  always_ff @(posedge dac_clk) begin
    if (wr_enable) begin
      mem[wr_address] <= wr_data;
    end
  end

  always_ff @(posedge dac_clk) begin
    rd_data <= mem[rd_word_s][rd_lane_s*b_data_width +: b_data_width];
  end

endmodule

//--- rtl/dac_fifo_drain.sv
// Hands one sample per dac_valid to the DAC, with no back-pressure.
// After the last valid sample of the waveform's last word the pointer jumps
// to the next word. Several copies of the last word may sit in the buffer,
// so each word slot keeps its own flag.

module dac_fifo_drain (
  input  logic                                            dac_clk,
  input  logic                                            dac_reset,
  input  logic                                            xfer_enable,
  input  logic [dac_fifo_pkg::avl_byteenable_width-1:0]   last_byteenable,
  input  logic [dac_fifo_pkg::avl_mem_address_width-1:0]  wr_address,
  input  logic                                            last_word_written,
  input  logic [dac_fifo_pkg::dac_data_width-1:0]         rd_data,
  input  logic                                            dac_valid,
  output logic [dac_fifo_pkg::dac_mem_address_width-1:0]  rd_address,
  output logic [dac_fifo_pkg::dac_data_width-1:0]         dac_data,
  output logic                                            dac_xfer_req,
  output logic                                            dac_dunf
);

  logic [dac_fifo_pkg::dac_mem_address_width-1:0] fill_s;
  logic [dac_fifo_pkg::last_beats_width-1:0] last_beats_s;
  logic [dac_fifo_pkg::last_beats_width-1:0] rd_lane_s;
  logic [dac_fifo_pkg::avl_mem_address_width-1:0] rd_word_s;
  logic [2**dac_fifo_pkg::avl_mem_address_width-1:0] last_flag;
  logic rd_en_s;
  logic word_end_s;
  logic taken;

  assign fill_s = {wr_address, {dac_fifo_pkg::last_beats_width{1'b0}}} - rd_address;
  assign rd_word_s = rd_address[dac_fifo_pkg::dac_mem_address_width-1 -:
                                dac_fifo_pkg::avl_mem_address_width];
  assign rd_lane_s = rd_address[dac_fifo_pkg::last_beats_width-1:0];
  assign rd_en_s = dac_valid & dac_xfer_req & (fill_s != '0);

  // Count full sample lanes from lane 0 until the first incomplete one
  always_comb begin
    last_beats_s = '0;
    for (int i = 1; i < dac_fifo_pkg::mem_ratio; i++) begin
      if (&last_byteenable[i*(dac_fifo_pkg::dac_data_width/8) +: dac_fifo_pkg::dac_data_width/8]
          && (last_beats_s == dac_fifo_pkg::last_beats_width'(i - 1))) begin
        last_beats_s = dac_fifo_pkg::last_beats_width'(i);
      end
    end
  end

  assign word_end_s = last_flag[rd_word_s] ? (rd_lane_s == last_beats_s) : (&rd_lane_s);

  // ======================================================================
  // Read pointer and last-word flags
  // ======================================================================

  always_ff @(posedge dac_clk) begin
    if (dac_reset || (!xfer_enable && !dac_xfer_req)) begin
      rd_address <= '0;
      last_flag <= '0;
    end else begin
      if (rd_en_s && word_end_s) begin
        rd_address <= {rd_word_s + 1'b1, {dac_fifo_pkg::last_beats_width{1'b0}}};
        last_flag[rd_word_s] <= 1'b0;
      end else if (rd_en_s) begin
        rd_address <= rd_address + 1'b1;
      end
      if (last_word_written) begin
        last_flag[wr_address] <= 1'b1;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_xfer_req <= 1'b0;
    end else if (xfer_enable && (fill_s != '0)) begin
      dac_xfer_req <= 1'b1;
    end else if (!xfer_enable && (fill_s == '0)) begin
      dac_xfer_req <= 1'b0;
    end
  end

  // The buffer registers the sample, so only the taken flag is kept here
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      taken <= 1'b0;
      dac_dunf <= 1'b0;
    end else begin
      taken <= rd_en_s;
      dac_dunf <= dac_valid & dac_xfer_req & (fill_s == '0);
    end
  end

  assign dac_data = taken ? rd_data : '0;

  // If the read pointer overtook the write pointer the fill would jump up
  assert property (@(posedge dac_clk) disable iff (dac_reset)
    xfer_enable && $past(xfer_enable) |-> fill_s <= $past(fill_s) + dac_fifo_pkg::mem_ratio)
    else $error("Drain read pointer passed the write pointer");

endmodule

//--- rtl/dac_fifo_pkg.sv
// Shared widths, fill thresholds and APB register offsets of the DAC FIFO.
// The buffer holds 16 memory words of 4 samples each. Thresholds count whole
// words, so the word that the drain is reading still counts as filled.

package dac_fifo_pkg;

  // ======================================================================
  // Data path widths
  // ======================================================================

  localparam int avl_data_width = 128;
  localparam int dac_data_width = 32;
  localparam int mem_ratio = 4;
  localparam int dac_mem_address_width = 6;
  localparam int avl_mem_address_width = 4;
  localparam int avl_address_width = 12;
  localparam int avl_byteenable_width = 16;
  localparam int last_beats_width = 2;

  // Read hysteresis on the buffer fill level, in words
  localparam int mem_threshold_lo = 4;
  localparam int mem_threshold_hi = 12;

  // ======================================================================
  // APB register map
  // ======================================================================

  localparam int apb_address_width = 8;
  localparam int apb_data_width = 32;

  // Bit 0 is the transfer enable
  localparam logic [apb_address_width-1:0] reg_control = 8'h00;
  localparam logic [apb_address_width-1:0] reg_last_address = 8'h04;
  localparam logic [apb_address_width-1:0] reg_last_byteenable = 8'h08;
  // Bit 0 is the sticky underflow flag, write 1 to clear
  localparam logic [apb_address_width-1:0] reg_status = 8'h0C;

endpackage

//--- rtl/dac_fifo_regs.sv
// APB control registers of the DAC FIFO.
// pready is tied high, so every access is one setup and one access cycle.
// Unmapped offsets answer with pslverr and read as zero.

module dac_fifo_regs (
  input  logic                                        dac_clk,
  input  logic                                        dac_reset,
  input  logic [dac_fifo_pkg::apb_address_width-1:0]  paddr,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [dac_fifo_pkg::apb_data_width-1:0]     pwdata,
  input  logic                                        dac_dunf,
  output logic [dac_fifo_pkg::apb_data_width-1:0]     prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  output logic                                        xfer_enable,
  output logic [dac_fifo_pkg::avl_address_width-1:0]  last_address,
  output logic [dac_fifo_pkg::avl_byteenable_width-1:0] last_byteenable
);

  logic access_s;
  logic mapped_s;
  logic underflow;

  assign access_s = psel & penable;
  assign pready = 1'b1;
  assign pslverr = access_s & ~mapped_s;

  // The read mux also flags offsets outside the map
  always_comb begin
    prdata = '0;
    mapped_s = 1'b1;
    case (paddr)
      dac_fifo_pkg::reg_control: prdata[0] = xfer_enable;
      dac_fifo_pkg::reg_last_address:
        prdata[dac_fifo_pkg::avl_address_width-1:0] = last_address;
      dac_fifo_pkg::reg_last_byteenable:
        prdata[dac_fifo_pkg::avl_byteenable_width-1:0] = last_byteenable;
      dac_fifo_pkg::reg_status: prdata[0] = underflow;
      default: mapped_s = 1'b0;
    endcase
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      xfer_enable <= 1'b0;
      last_address <= '0;
      last_byteenable <= '0;
    end else if (access_s && pwrite) begin
      case (paddr)
        dac_fifo_pkg::reg_control: xfer_enable <= pwdata[0];
        dac_fifo_pkg::reg_last_address:
          last_address <= pwdata[dac_fifo_pkg::avl_address_width-1:0];
        dac_fifo_pkg::reg_last_byteenable:
          last_byteenable <= pwdata[dac_fifo_pkg::avl_byteenable_width-1:0];
        default: ;
      endcase
    end
  end

  // A new underflow wins over a clear in the same cycle
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      underflow <= 1'b0;
    end else if (dac_dunf) begin
      underflow <= 1'b1;
    end else if (access_s && pwrite && (paddr == dac_fifo_pkg::reg_status) && pwdata[0]) begin
      underflow <= 1'b0;
    end
  end

  // The master opens every access with a setup cycle
  assert property (@(posedge dac_clk) disable iff (dac_reset)
    penable |-> psel && $past(psel))
    else $error("APB penable without a preceding psel");

endmodule

//--- rtl/dac_fifo_top.sv
// DAC playback FIFO, read side only, everything on dac_clk.
// APB sets up and starts the transfer, memory is read over Avalon-MM and the
// DAC pulls samples with dac_valid.

module dac_fifo_top (
  input  logic                                          dac_clk,
  input  logic                                          dac_reset,
  input  logic [dac_fifo_pkg::apb_address_width-1:0]    paddr,
  input  logic                                          psel,
  input  logic                                          penable,
  input  logic                                          pwrite,
  input  logic [dac_fifo_pkg::apb_data_width-1:0]       pwdata,
  output logic [dac_fifo_pkg::apb_data_width-1:0]       prdata,
  output logic                                          pready,
  output logic                                          pslverr,
  output logic [dac_fifo_pkg::avl_address_width-1:0]    avl_address,
  output logic                                          avl_read,
  output logic [dac_fifo_pkg::avl_byteenable_width-1:0] avl_byteenable,
  input  logic                                          avl_ready,
  input  logic                                          avl_readdatavalid,
  input  logic [dac_fifo_pkg::avl_data_width-1:0]       avl_data,
  input  logic                                          dac_valid,
  output logic [dac_fifo_pkg::dac_data_width-1:0]       dac_data,
  output logic                                          dac_xfer_req,
  output logic                                          dac_dunf
);

  logic xfer_enable;
  logic [dac_fifo_pkg::avl_address_width-1:0] last_address;
  logic [dac_fifo_pkg::avl_byteenable_width-1:0] last_byteenable;
  logic wr_enable;
  logic [dac_fifo_pkg::avl_mem_address_width-1:0] wr_address;
  logic [dac_fifo_pkg::avl_data_width-1:0] wr_data;
  logic [dac_fifo_pkg::dac_mem_address_width-1:0] rd_address;
  logic [dac_fifo_pkg::dac_data_width-1:0] rd_data;
  logic last_word_written;

  dac_fifo_regs i_regs (
    .dac_clk (dac_clk),
    .dac_reset (dac_reset),
    .paddr (paddr),
    .psel (psel),
    .penable (penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .dac_dunf (dac_dunf),
    .prdata (prdata),
    .pready (pready),
    .pslverr (pslverr),
    .xfer_enable (xfer_enable),
    .last_address (last_address),
    .last_byteenable (last_byteenable)
  );

  avl_dacfifo_fetch i_fetch (
    .dac_clk (dac_clk),
    .dac_reset (dac_reset),
    .xfer_enable (xfer_enable),
    .last_address (last_address),
    .last_byteenable (last_byteenable),
    .avl_ready (avl_ready),
    .avl_readdatavalid (avl_readdatavalid),
    .avl_data (avl_data),
    .rd_address (rd_address),
    .avl_address (avl_address),
    .avl_read (avl_read),
    .avl_byteenable (avl_byteenable),
    .wr_enable (wr_enable),
    .wr_address (wr_address),
    .wr_data (wr_data),
    .last_word_written (last_word_written)
  );

  dac_fifo_buffer #(
    .a_address_width (dac_fifo_pkg::avl_mem_address_width),
    .b_address_width (dac_fifo_pkg::dac_mem_address_width),
    .a_data_width (dac_fifo_pkg::avl_data_width),
    .b_data_width (dac_fifo_pkg::dac_data_width)
  ) i_buffer (
    .dac_clk (dac_clk),
    .wr_enable (wr_enable),
    .wr_address (wr_address),
    .wr_data (wr_data),
    .rd_address (rd_address),
    .rd_data (rd_data)
  );

  dac_fifo_drain i_drain (
    .dac_clk (dac_clk),
    .dac_reset (dac_reset),
    .xfer_enable (xfer_enable),
    .last_byteenable (last_byteenable),
    .wr_address (wr_address),
    .last_word_written (last_word_written),
    .rd_data (rd_data),
    .dac_valid (dac_valid),
    .rd_address (rd_address),
    .dac_data (dac_data),
    .dac_xfer_req (dac_xfer_req),
    .dac_dunf (dac_dunf)
  );

endmodule

//--- verification/tb_avl_memory.sv
// Avalon-MM read memory model for the DAC FIFO testbench.
// Lane k of word a holds mem_ratio*a + k, so a good stream counts up by one.
// One read is served at a time, 1 to 6 cycles after it is taken, or 9 to 14
// cycles while slow is high. avl_ready drops at random.

module tb_avl_memory (
  input  logic                                        dac_clk,
  input  logic                                        dac_reset,
  input  logic                                        slow,
  input  logic [dac_fifo_pkg::avl_address_width-1:0]  avl_address,
  input  logic                                        avl_read,
  output logic                                        avl_ready,
  output logic                                        avl_readdatavalid,
  output logic [dac_fifo_pkg::avl_data_width-1:0]     avl_data
);

  int seed = 91050;
  int delay = 0;
  logic pending = 1'b0;
  logic accept_v;
  logic slow_v;
  logic [dac_fifo_pkg::avl_address_width-1:0] address_v;
  logic [dac_fifo_pkg::avl_address_width-1:0] address_q = '0;
  logic ready_q = 1'b0;
  logic valid_q = 1'b0;
  logic [dac_fifo_pkg::avl_data_width-1:0] data_q = '0;

  assign avl_ready = ready_q;
  assign avl_readdatavalid = valid_q;
  assign avl_data = data_q;

  // Bus inputs are taken at the edge, the outputs change 2 units later
  always @(posedge dac_clk) begin
    accept_v = avl_read && ready_q;
    address_v = avl_address;
    slow_v = slow;
    #2;
    valid_q = 1'b0;
    if (dac_reset) begin
      ready_q = 1'b0;
      pending = 1'b0;
    end else begin
      if (accept_v) begin
        address_q = address_v;
        delay = {$random(seed)} % 6 + (slow_v ? 8 : 0);
        pending = 1'b1;
      end
      if (pending && delay == 0) begin
        valid_q = 1'b1;
        for (int k = 0; k < dac_fifo_pkg::mem_ratio; k++) begin
          data_q[k*dac_fifo_pkg::dac_data_width +: dac_fifo_pkg::dac_data_width] =
            dac_fifo_pkg::mem_ratio * address_q + k;
        end
        pending = 1'b0;
      end else if (pending) begin
        delay--;
      end
      // Ready is low about one cycle in four
      ready_q = ({$random(seed)} % 4) != 0;
    end
  end

endmodule

//--- verification/tb_dac_fifo.sv
// Testbench for the DAC FIFO read side.
// Checks are immediate assertions, mostly in a monitor on the falling edge.
// Every pulled sample must be the previous one plus 1, wrapping to 0 at the
// end of the waveform. Underflow samples are zero and are skipped.

module tb_dac_fifo;

  localparam int until_samples = 0;
  localparam int until_underflow = 1;
  localparam int until_idle = 2;

  // Cycle budgets of the phases
  localparam int reset_cycles = 5;
  localparam int setup_cycles = 80;
  localparam int stream_cycles = 400;
  localparam int idle_cycles = 300;
  localparam int underflow_cycles = 200;
  localparam int watchdog_cycles = 4 * (reset_cycles + setup_cycles + 3 * stream_cycles +
                                        3 * idle_cycles + underflow_cycles);

  logic dac_clk = 1'b0;
  logic dac_reset = 1'b1;
  logic [dac_fifo_pkg::apb_address_width-1:0] paddr = '0;
  logic psel = 1'b0;
  logic penable = 1'b0;
  logic pwrite = 1'b0;
  logic [dac_fifo_pkg::apb_data_width-1:0] pwdata = '0;
  logic [dac_fifo_pkg::apb_data_width-1:0] prdata;
  logic pready;
  logic pslverr;
  logic [dac_fifo_pkg::avl_address_width-1:0] avl_address;
  logic avl_read;
  logic [dac_fifo_pkg::avl_byteenable_width-1:0] avl_byteenable;
  logic avl_ready;
  logic avl_readdatavalid;
  logic [dac_fifo_pkg::avl_data_width-1:0] avl_data;
  logic dac_valid = 1'b0;
  logic [dac_fifo_pkg::dac_data_width-1:0] dac_data;
  logic dac_xfer_req;
  logic dac_dunf;
  logic mem_slow = 1'b0;

  int errors = 0;
  int valid_period = 0;
  int cycle_count = 0;
  int wrap_len = 0;
  int samples = 0;
  int sample_target = 0;
  int wraps = 0;
  logic pulled = 1'b0;
  logic stream_on = 1'b0;
  logic have_prev = 1'b0;
  logic dunf_seen = 1'b0;
  logic stopped = 1'b0;
  logic next_valid;
  logic [31:0] prev_sample = '0;
  logic [31:0] expected_sample;
  logic [dac_fifo_pkg::avl_address_width-1:0] cfg_last_address = '0;
  logic [dac_fifo_pkg::avl_byteenable_width-1:0] cfg_byteenable = '0;

  dac_fifo_top dut (
    .dac_clk (dac_clk),
    .dac_reset (dac_reset),
    .paddr (paddr),
    .psel (psel),
    .penable (penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr (pslverr),
    .avl_address (avl_address),
    .avl_read (avl_read),
    .avl_byteenable (avl_byteenable),
    .avl_ready (avl_ready),
    .avl_readdatavalid (avl_readdatavalid),
    .avl_data (avl_data),
    .dac_valid (dac_valid),
    .dac_data (dac_data),
    .dac_xfer_req (dac_xfer_req),
    .dac_dunf (dac_dunf)
  );

  tb_avl_memory i_memory (
    .dac_clk (dac_clk),
    .dac_reset (dac_reset),
    .slow (mem_slow),
    .avl_address (avl_address),
    .avl_read (avl_read),
    .avl_ready (avl_ready),
    .avl_readdatavalid (avl_readdatavalid),
    .avl_data (avl_data)
  );

  always #10 dac_clk = ~dac_clk;

  // The DAC pulls one sample every valid_period cycles, never while it is 0
  always @(posedge dac_clk) begin
    cycle_count++;
    next_valid = (valid_period != 0) && (cycle_count % valid_period == 0);
    #2;
    dac_valid = next_valid;
  end

  function automatic void check_value(input string name, input logic [31:0] expected,
                                      input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
    end
  endfunction

  function automatic logic [31:0] next_sample(input logic [31:0] sample);
    if (sample + 1 == wrap_len) begin
      return '0;
    end else begin
      return sample + 1;
    end
  endfunction

  // ====================================================================
  // Monitor on the falling edge where every output is stable
  // ====================================================================

  always @(negedge dac_clk) begin
    if (dac_reset) begin
      pulled = 1'b0;
    end else begin
      if (pulled && dac_dunf) begin
        dunf_seen = 1'b1;
        check_value("dac_data", '0, dac_data);
      end else if (pulled && stream_on) begin
        expected_sample = have_prev ? next_sample(prev_sample) : '0;
        check_value("dac_data", expected_sample, dac_data);
        if (have_prev && expected_sample == 0) begin
          wraps++;
        end
        prev_sample = dac_data;
        have_prev = 1'b1;
        samples++;
      end
      if (!pulled) begin
        check_value("dac_dunf", 0, dac_dunf);
      end
      if (stopped) begin
        check_value("avl_read", 0, avl_read);
      end
      // Only the last word of the waveform carries the partial byte enables
      if (avl_read) begin
        check_value("avl_byteenable",
                    (avl_address == cfg_last_address) ? cfg_byteenable :
                      {dac_fifo_pkg::avl_byteenable_width{1'b1}},
                    avl_byteenable);
      end
      pulled = dac_valid && dac_xfer_req;
    end
  end

  // For a read, data is the expected prdata
  task automatic apb_transfer(input logic write, input logic [7:0] address,
                              input logic [31:0] data, input logic expect_error);
    @(posedge dac_clk);
    #2;
    paddr = address;
    pwrite = write;
    pwdata = write ? data : '0;
    psel = 1'b1;
    @(posedge dac_clk);
    #2;
    penable = 1'b1;
    @(negedge dac_clk);
    check_value("pready", 1, pready);
    check_value("pslverr", expect_error, pslverr);
    if (!write) begin
      check_value("prdata", data, prdata);
    end
    @(posedge dac_clk);
    #2;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  function automatic logic condition_met(input int kind);
    case (kind)
      until_samples: return samples >= sample_target;
      until_underflow: return dunf_seen;
      default: return !dac_xfer_req;
    endcase
  endfunction

  task automatic wait_until(input int kind, input int limit, input string what);
    int n;
    n = 0;
    while (!condition_met(kind) && n < limit) begin
      @(negedge dac_clk);
      n++;
    end
    assert (condition_met(kind)) else begin
      errors++;
      $display("ERROR time=%0t gave up waiting for %s after %0d cycles", $time, what, limit);
    end
  endtask

  task automatic set_waveform(input logic [11:0] last_address, input logic [15:0] byteenable);
    apb_transfer(1'b1, dac_fifo_pkg::reg_last_address, 32'(last_address), 1'b0);
    apb_transfer(1'b1, dac_fifo_pkg::reg_last_byteenable, 32'(byteenable), 1'b0);
    cfg_last_address = last_address;
    cfg_byteenable = byteenable;
  endtask

  task automatic play(input int period, input int count);
    valid_period = period;
    samples = 0;
    wraps = 0;
    have_prev = 1'b0;
    dunf_seen = 1'b0;
    stream_on = 1'b1;
    sample_target = count;
    apb_transfer(1'b1, dac_fifo_pkg::reg_control, 32'h1, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_control, 32'h1, 1'b0);
    wait_until(until_samples, stream_cycles, "the sample stream");
  endtask

  task automatic stop_playback();
    stream_on = 1'b0;
    apb_transfer(1'b1, dac_fifo_pkg::reg_control, 32'h0, 1'b0);
    wait_until(until_idle, idle_cycles, "dac_xfer_req to fall");
  endtask

  task automatic check_wrapped();
    assert (wraps >= 2) else begin
      errors++;
      $display("ERROR time=%0t the sample stream wrapped %0d times, expected at least 2",
               $time, wraps);
    end
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    repeat (reset_cycles) @(posedge dac_clk);
    #2;
    dac_reset = 1'b0;
    @(negedge dac_clk);
    check_value("dac_xfer_req", 0, dac_xfer_req);
    check_value("dac_dunf", 0, dac_dunf);
    check_value("avl_read", 0, avl_read);
    check_value("pslverr", 0, pslverr);
    apb_transfer(1'b0, dac_fifo_pkg::reg_control, 32'h0, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_last_address, 32'h0, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_last_byteenable, 32'h0, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_status, 32'h0, 1'b0);

    // Read back, then an offset outside the map
    apb_transfer(1'b1, dac_fifo_pkg::reg_last_address, 32'h0000_0abc, 1'b0);
    apb_transfer(1'b1, dac_fifo_pkg::reg_last_byteenable, 32'h0000_5a0f, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_last_address, 32'h0000_0abc, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_last_byteenable, 32'h0000_5a0f, 1'b0);
    apb_transfer(1'b1, 8'h10, 32'hffff_ffff, 1'b1);
    apb_transfer(1'b0, 8'h10, 32'h0, 1'b1);

    // Six full words make 24 samples
    set_waveform(12'd5, 16'hffff);
    wrap_len = 6 * dac_fifo_pkg::mem_ratio;
    play(3, 60);
    check_wrapped();
    stop_playback();

    // Eight bytes leave two samples in the last word
    set_waveform(12'd5, 16'h00ff);
    wrap_len = 5 * dac_fifo_pkg::mem_ratio + 2;
    play(3, 50);
    check_wrapped();
    stop_playback();

    mem_slow = 1'b1;
    play(1, 1);
    wait_until(until_underflow, underflow_cycles, "an underflow");
    apb_transfer(1'b0, dac_fifo_pkg::reg_status, 32'h1, 1'b0);
    valid_period = 0;
    repeat (3) @(posedge dac_clk);
    apb_transfer(1'b1, dac_fifo_pkg::reg_status, 32'h1, 1'b0);
    apb_transfer(1'b0, dac_fifo_pkg::reg_status, 32'h0, 1'b0);

    // Playback goes on, then stops for good
    mem_slow = 1'b0;
    valid_period = 1;
    sample_target = samples + 40;
    wait_until(until_samples, stream_cycles, "samples after the underflow");
    stream_on = 1'b0;
    apb_transfer(1'b1, dac_fifo_pkg::reg_control, 32'h0, 1'b0);
    @(posedge dac_clk);
    #2;
    stopped = 1'b1;
    wait_until(until_idle, idle_cycles, "dac_xfer_req to fall after the stop");

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * 20);
    $display("ERROR watchdog expired after %0d cycles before the tests finished",
             watchdog_cycles);
    $display("Checks done with %0d errors", errors);
    $display("Regression failed");
    $finish;
  end

endmodule
